// ==== verilog/dp_pkg.sv ====
// Datapath widths, bank address maps, ALU opcodes and the instruction, write and I/O types
package dp_pkg;

    // ------------------------------
    // Widths
    // ------------------------------

    localparam int word_w        = 16;
    localparam int addr_w        = 10;

    // Low address bits index the RAM
    localparam int mem_addr_w    = 8;

    localparam int io_port_count = 2;

    // I/O ports sit at io_base_addr and up, in both banks
    localparam int io_base_addr  = 512;

    // ------------------------------
    // Bank address maps
    // ------------------------------

    // Bank A depth is set by its smaller write range, so 1 to 191
    localparam int mem_read_base_a   = 1;
    localparam int mem_read_bound_a  = 255;
    localparam int mem_write_base_a  = 1;
    localparam int mem_write_bound_a = 191;

    localparam int mem_read_base_b   = 1;
    localparam int mem_read_bound_b  = 127;
    localparam int mem_write_base_b  = 1;
    localparam int mem_write_bound_b = 127;

    // ------------------------------
    // Types
    // ------------------------------

    typedef logic [word_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;

    // One word per I/O port
    typedef word_t [io_port_count-1:0] io_words_t;

    typedef enum logic [2:0] {
        op_add    = 3'd0,
        op_sub    = 3'd1,
        op_and    = 3'd2,
        op_or     = 3'd3,
        op_xor    = 3'd4,
        op_pass_a = 3'd5
    } alu_op_e;

    // Instruction as it arrives, already decoded and translated
    typedef struct packed {
        logic    issue;
        logic    ior;
        logic    cancel;
        alu_op_e op;
        addr_t   read_addr_a;
        addr_t   read_addr_b;
        addr_t   write_addr_a;
        addr_t   write_addr_b;
    } instr_t;

    // Write-back request to one bank, flags are the delayed copies
    typedef struct packed {
        logic  ior;
        logic  cancel;
        addr_t addr;
        word_t data;
    } mem_write_t;

endpackage

// ==== verilog/mem_addressing.sv ====
// Address range decode and annul gating for one data memory bank
`timescale 1ns/100ps

module mem_addressing #(
    parameter int read_base   = 1,
    parameter int read_bound  = 1,
    parameter int write_base  = 1,
    parameter int write_bound = 1
) (
    input  logic          ior,
    input  logic          cancel,
    input  dp_pkg::addr_t read_addr,
    input  logic          write_ior,
    input  logic          write_cancel,
    input  dp_pkg::addr_t write_addr,
    output logic          read_mem_en,
    output logic          read_io_en,
    output logic          write_mem_en,
    output logic          write_io_en
);

    // Smaller range sets the usable depth for both directions
    localparam int read_depth  = read_bound - read_base + 1;
    localparam int write_depth = write_bound - write_base + 1;
    localparam int mem_depth   = (read_depth <= write_depth) ? read_depth : write_depth;

    localparam dp_pkg::addr_t read_lo  = dp_pkg::addr_t'(read_base);
    localparam dp_pkg::addr_t read_hi  = dp_pkg::addr_t'(read_base + mem_depth - 1);
    localparam dp_pkg::addr_t write_lo = dp_pkg::addr_t'(write_base);
    localparam dp_pkg::addr_t write_hi = dp_pkg::addr_t'(write_base + mem_depth - 1);

    localparam dp_pkg::addr_t io_lo = dp_pkg::addr_t'(dp_pkg::io_base_addr);
    localparam dp_pkg::addr_t io_hi =
        dp_pkg::addr_t'(dp_pkg::io_base_addr + dp_pkg::io_port_count - 1);

    logic read_live;
    logic write_live;

    // Annulled instructions touch nothing
    assign read_live  = !(ior || cancel);
    assign write_live = !(write_ior || write_cancel);

    // Address 0 lies below every base, so it never decodes
    assign read_mem_en  = read_live && (read_addr >= read_lo) && (read_addr <= read_hi);
    assign read_io_en   = read_live && (read_addr >= io_lo) && (read_addr <= io_hi);

    assign write_mem_en = write_live && (write_addr >= write_lo) && (write_addr <= write_hi);
    assign write_io_en  = write_live && (write_addr >= io_lo) && (write_addr <= io_hi);

endmodule

// ==== verilog/data_memory.sv ====
// One data memory bank with RAM, I/O ports, zero location and registered read
`timescale 1ns/100ps

module data_memory #(
    parameter int read_base   = 1,
    parameter int read_bound  = 1,
    parameter int write_base  = 1,
    parameter int write_bound = 1
) (
    input  logic                              clock,
    input  logic                              rst_n,

    // Current instruction side
    input  logic                              ior,
    input  logic                              cancel,
    input  dp_pkg::addr_t                     read_addr,
    output dp_pkg::word_t                     read_data,

    // Write-back from the ALU
    input  dp_pkg::mem_write_t                write_req,

    // Outside world
    input  dp_pkg::io_words_t                 io_read_data,
    output logic [dp_pkg::io_port_count-1:0]  io_wren,
    output dp_pkg::io_words_t                 io_write_data
);

    localparam int mem_words = 1 << dp_pkg::mem_addr_w;
    localparam int port_w    = $clog2(dp_pkg::io_port_count);

    logic                         read_mem_en;
    logic                         read_io_en;
    logic                         write_mem_en;
    logic                         write_io_en;

    logic [dp_pkg::mem_addr_w-1:0] read_index;
    logic [dp_pkg::mem_addr_w-1:0] write_index;
    logic [port_w-1:0]             read_port;
    logic [port_w-1:0]             write_port;

    // Array covers the whole index space, the decoder limits the usable part
    dp_pkg::word_t ram [mem_words] = '{default: '0};

    // ------------------------------
    // Address decode
    // ------------------------------

    mem_addressing #(
        .read_base    (read_base),
        .read_bound   (read_bound),
        .write_base   (write_base),
        .write_bound  (write_bound)
    ) addressing (
        .ior          (ior),
        .cancel       (cancel),
        .read_addr    (read_addr),
        .write_ior    (write_req.ior),
        .write_cancel (write_req.cancel),
        .write_addr   (write_req.addr),
        .read_mem_en  (read_mem_en),
        .read_io_en   (read_io_en),
        .write_mem_en (write_mem_en),
        .write_io_en  (write_io_en)
    );

    // I/O base is aligned, so the low bits give the port number
    assign read_index  = read_addr[dp_pkg::mem_addr_w-1:0];
    assign write_index = write_req.addr[dp_pkg::mem_addr_w-1:0];
    assign read_port   = read_addr[port_w-1:0];
    assign write_port  = write_req.addr[port_w-1:0];

    // ------------------------------
    // RAM and read path
    // ------------------------------

    always_ff @(posedge clock) begin
        if (write_mem_en) begin
            ram[write_index] <= write_req.data;
        end
    end

    // Read before write on a shared edge, no forwarding
    always_ff @(posedge clock) begin
        if (read_mem_en) begin
            read_data <= ram[read_index];
        end else if (read_io_en) begin
            read_data <= io_read_data[read_port];
        end else begin
            // Unmapped or annulled reads give zero
            read_data <= '0;
        end
    end

    // ------------------------------
    // I/O write ports
    // ------------------------------

    // Strobe lasts one cycle per write
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            io_wren <= '0;
        end else begin
            io_wren <= '0;
            if (write_io_en) begin
                io_wren[write_port] <= 1'b1;
            end
        end
    end

    // Port data holds until the next write to that port
    always_ff @(posedge clock) begin
        if (write_io_en) begin
            io_write_data[write_port] <= write_req.data;
        end
    end

endmodule

// ==== verilog/datapath_alu.sv ====
// Two-stage execute pipeline combining both banks' reads and building write-back
`timescale 1ns/100ps

module datapath_alu (
    input  logic               clock,
    input  logic               rst_n,
    input  dp_pkg::instr_t     instr,
    input  dp_pkg::word_t      read_data_a,
    input  dp_pkg::word_t      read_data_b,
    output dp_pkg::word_t      result,
    output dp_pkg::alu_op_e    result_op,
    output logic               result_valid,
    output dp_pkg::mem_write_t write_req_a,
    output dp_pkg::mem_write_t write_req_b
);

    // Stage one, alongside the bank reads
    logic            s1_issue;
    logic            s1_ior;
    logic            s1_cancel;
    dp_pkg::alu_op_e s1_op;
    dp_pkg::addr_t   s1_write_addr_a;
    dp_pkg::addr_t   s1_write_addr_b;

    // Stage two, alongside the result
    logic            s2_ior;
    logic            s2_cancel;
    dp_pkg::addr_t   s2_write_addr_a;
    dp_pkg::addr_t   s2_write_addr_b;

    dp_pkg::word_t   alu_out;

    // ------------------------------
    // Pipeline control
    // ------------------------------

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            s1_issue     <= 1'b0;
            s1_ior       <= 1'b0;
            s1_cancel    <= 1'b0;
            result_valid <= 1'b0;
            s2_ior       <= 1'b0;
            s2_cancel    <= 1'b0;
        end else begin
            s1_issue     <= instr.issue;
            s1_ior       <= instr.ior;
            s1_cancel    <= instr.cancel;
            result_valid <= s1_issue;
            s2_ior       <= s1_ior;
            s2_cancel    <= s1_cancel;
        end
    end

    always_ff @(posedge clock) begin
        s1_op           <= instr.op;
        s1_write_addr_a <= instr.write_addr_a;
        s1_write_addr_b <= instr.write_addr_b;
        s2_write_addr_a <= s1_write_addr_a;
        s2_write_addr_b <= s1_write_addr_b;
        result          <= alu_out;
        result_op       <= s1_op;
    end

    // ------------------------------
    // Operation, wraparound arithmetic
    // ------------------------------

    always_comb begin
        case (s1_op)
            dp_pkg::op_add:    alu_out = read_data_a + read_data_b;
            dp_pkg::op_sub:    alu_out = read_data_a - read_data_b;
            dp_pkg::op_and:    alu_out = read_data_a & read_data_b;
            dp_pkg::op_or:     alu_out = read_data_a | read_data_b;
            dp_pkg::op_xor:    alu_out = read_data_a ^ read_data_b;
            dp_pkg::op_pass_a: alu_out = read_data_a;
            default:           alu_out = '0;
        endcase
    end

    // Empty slot counts as annulled, so bubbles never write
    always_comb begin
        write_req_a.ior    = s2_ior || !result_valid;
        write_req_a.cancel = s2_cancel;
        write_req_a.addr   = s2_write_addr_a;
        write_req_a.data   = result;
        write_req_b.ior    = s2_ior || !result_valid;
        write_req_b.cancel = s2_cancel;
        write_req_b.addr   = s2_write_addr_b;
        write_req_b.data   = result;
    end

endmodule

// ==== verilog/datapath_top.sv ====
// Datapath top level joining memory banks A and B with the ALU
`timescale 1ns/100ps

module datapath_top (
    input  logic                              clock,
    input  logic                              rst_n,
    input  dp_pkg::instr_t                    instr,

    // I/O ports of both banks
    input  dp_pkg::io_words_t                 io_read_data_a,
    input  dp_pkg::io_words_t                 io_read_data_b,
    output dp_pkg::io_words_t                 io_write_data_a,
    output dp_pkg::io_words_t                 io_write_data_b,
    output logic [dp_pkg::io_port_count-1:0]  io_wren_a,
    output logic [dp_pkg::io_port_count-1:0]  io_wren_b,

    // Execute result
    output dp_pkg::word_t                     result,
    output dp_pkg::alu_op_e                   result_op,
    output logic                              result_valid
);

    dp_pkg::word_t      read_data_a;
    dp_pkg::word_t      read_data_b;
    dp_pkg::mem_write_t write_req_a;
    dp_pkg::mem_write_t write_req_b;

    // ------------------------------
    // Bank A
    // ------------------------------

    data_memory #(
        .read_base     (dp_pkg::mem_read_base_a),
        .read_bound    (dp_pkg::mem_read_bound_a),
        .write_base    (dp_pkg::mem_write_base_a),
        .write_bound   (dp_pkg::mem_write_bound_a)
    ) bank_a (
        .clock         (clock),
        .rst_n         (rst_n),
        .ior           (instr.ior),
        .cancel        (instr.cancel),
        .read_addr     (instr.read_addr_a),
        .read_data     (read_data_a),
        .write_req     (write_req_a),
        .io_read_data  (io_read_data_a),
        .io_wren       (io_wren_a),
        .io_write_data (io_write_data_a)
    );

    // ------------------------------
    // Bank B
    // ------------------------------

    data_memory #(
        .read_base     (dp_pkg::mem_read_base_b),
        .read_bound    (dp_pkg::mem_read_bound_b),
        .write_base    (dp_pkg::mem_write_base_b),
        .write_bound   (dp_pkg::mem_write_bound_b)
    ) bank_b (
        .clock         (clock),
        .rst_n         (rst_n),
        .ior           (instr.ior),
        .cancel        (instr.cancel),
        .read_addr     (instr.read_addr_b),
        .read_data     (read_data_b),
        .write_req     (write_req_b),
        .io_read_data  (io_read_data_b),
        .io_wren       (io_wren_b),
        .io_write_data (io_write_data_b)
    );

    // ------------------------------
    // Execute
    // ------------------------------

    datapath_alu alu (
        .clock         (clock),
        .rst_n         (rst_n),
        .instr         (instr),
        .read_data_a   (read_data_a),
        .read_data_b   (read_data_b),
        .result        (result),
        .result_op     (result_op),
        .result_valid  (result_valid),
        .write_req_a   (write_req_a),
        .write_req_b   (write_req_b)
    );

endmodule

// ==== bench/datapath_assert.sv ====
// Concurrent assertions on I/O strobes, annulled writes and result timing of the datapath
`timescale 1ns/100ps

module datapath_assert (
    input logic                              clock,
    input logic                              rst_n,
    input dp_pkg::instr_t                    instr,
    input logic [dp_pkg::io_port_count-1:0]  io_wren_a,
    input logic [dp_pkg::io_port_count-1:0]  io_wren_b,
    input logic                              result_valid
);

    // Number of failed assertions
    int failures = 0;

    // ------------------------------
    // I/O strobes
    // ------------------------------

    // One port at most per bank, and only for an instruction issued three edges back
    wren_onehot_a: assert property (@(posedge clock) disable iff (!rst_n)
        (io_wren_a != '0) |-> ($onehot(io_wren_a) && $past(instr.issue, 3)))
        else begin
            failures = failures + 1;
            $error("io_wren_a strobes more than one port or follows an empty slot");
        end

    wren_onehot_b: assert property (@(posedge clock) disable iff (!rst_n)
        (io_wren_b != '0) |-> ($onehot(io_wren_b) && $past(instr.issue, 3)))
        else begin
            failures = failures + 1;
            $error("io_wren_b strobes more than one port or follows an empty slot");
        end

    // Annulled write would strobe three sampled edges after issue
    annul_no_wren: assert property (@(posedge clock) disable iff (!rst_n)
        (instr.ior || instr.cancel) |-> ##3 (io_wren_a == '0 && io_wren_b == '0))
        else begin
            failures = failures + 1;
            $error("io_wren raised by an annulled instruction");
        end

    // ------------------------------
    // Pipeline timing
    // ------------------------------

    valid_timing: assert property (@(posedge clock) disable iff (!rst_n)
        result_valid == $past(instr.issue, 2))
        else begin
            failures = failures + 1;
            $error("result_valid does not follow issue by two cycles");
        end

endmodule

// ==== bench/tb_datapath.sv ====
// Datapath testbench with clock, reset, seeded random instructions, cycle model and final report
`timescale 1ns/100ps

module tb_datapath;

    localparam int run_cycles = 4000;
    localparam int wait_limit = 20;
    localparam int ram_words  = 1 << dp_pkg::mem_addr_w;

    logic                              clock = 1'b0;
    logic                              rst_n;
    dp_pkg::instr_t                    instr;
    dp_pkg::io_words_t                 io_read_data_a;
    dp_pkg::io_words_t                 io_read_data_b;
    dp_pkg::io_words_t                 io_write_data_a;
    dp_pkg::io_words_t                 io_write_data_b;
    logic [dp_pkg::io_port_count-1:0]  io_wren_a;
    logic [dp_pkg::io_port_count-1:0]  io_wren_b;
    dp_pkg::word_t                     result;
    dp_pkg::alu_op_e                   result_op;
    logic                              result_valid;

    // Model of both banks, the pipeline and the expected I/O outputs
    dp_pkg::word_t                     ram_a [ram_words];
    dp_pkg::word_t                     ram_b [ram_words];
    dp_pkg::instr_t                    p1;
    dp_pkg::instr_t                    p2;
    dp_pkg::word_t                     p1_a;
    dp_pkg::word_t                     p1_b;
    dp_pkg::word_t                     p2_res;
    logic [dp_pkg::io_port_count-1:0]  exp_wren_a;
    logic [dp_pkg::io_port_count-1:0]  exp_wren_b;
    dp_pkg::io_words_t                 exp_wdata_a;
    dp_pkg::io_words_t                 exp_wdata_b;

    int checks;
    int mismatches;
    int timeouts;

    datapath_top DUT (.*);

    bind datapath_top datapath_assert assertions (
        .clock        (clock),
        .rst_n        (rst_n),
        .instr        (instr),
        .io_wren_a    (io_wren_a),
        .io_wren_b    (io_wren_b),
        .result_valid (result_valid)
    );

    always #5 clock = ~clock;

    // ------------------------------
    // Address map rules
    // ------------------------------

    // Usable depth is the smaller of the two ranges
    function automatic int bank_depth(input bit bank_b);
        int rd;
        int wr;
        rd = bank_b ? dp_pkg::mem_read_bound_b - dp_pkg::mem_read_base_b + 1
                    : dp_pkg::mem_read_bound_a - dp_pkg::mem_read_base_a + 1;
        wr = bank_b ? dp_pkg::mem_write_bound_b - dp_pkg::mem_write_base_b + 1
                    : dp_pkg::mem_write_bound_a - dp_pkg::mem_write_base_a + 1;
        return (rd < wr) ? rd : wr;
    endfunction

    function automatic bit in_range(input bit bank_b, input bit write, input dp_pkg::addr_t addr);
        int base;
        if (write) begin
            base = bank_b ? dp_pkg::mem_write_base_b : dp_pkg::mem_write_base_a;
        end else begin
            base = bank_b ? dp_pkg::mem_read_base_b : dp_pkg::mem_read_base_a;
        end
        return (addr >= base) && (addr < base + bank_depth(bank_b));
    endfunction

    function automatic bit is_io(input dp_pkg::addr_t addr);
        return (addr >= dp_pkg::io_base_addr) &&
               (addr < dp_pkg::io_base_addr + dp_pkg::io_port_count);
    endfunction

    // ------------------------------
    // Model
    // ------------------------------

    function automatic dp_pkg::word_t model_read(input bit bank_b, input dp_pkg::instr_t in,
                                                 input dp_pkg::io_words_t io_rd);
        dp_pkg::addr_t addr;
        addr = bank_b ? in.read_addr_b : in.read_addr_a;
        if (in.ior || in.cancel) begin
            return '0;
        end
        if (in_range(bank_b, 1'b0, addr)) begin
            return bank_b ? ram_b[addr] : ram_a[addr];
        end
        if (is_io(addr)) begin
            return io_rd[addr - dp_pkg::io_base_addr];
        end
        return '0;
    endfunction

    function automatic dp_pkg::word_t model_alu(input dp_pkg::alu_op_e op,
                                                input dp_pkg::word_t a, input dp_pkg::word_t b);
        case (op)
            dp_pkg::op_add:    return dp_pkg::word_t'(a + b);
            dp_pkg::op_sub:    return dp_pkg::word_t'(a - b);
            dp_pkg::op_and:    return a & b;
            dp_pkg::op_or:     return a | b;
            dp_pkg::op_xor:    return a ^ b;
            default:           return a;
        endcase
    endfunction

    task automatic apply_write(input bit bank_b, input dp_pkg::addr_t addr,
                               input dp_pkg::word_t data);
        int port;
        if (in_range(bank_b, 1'b1, addr)) begin
            if (bank_b) begin
                ram_b[addr] = data;
            end else begin
                ram_a[addr] = data;
            end
        end else if (is_io(addr)) begin
            port = addr - dp_pkg::io_base_addr;
            if (bank_b) begin
                exp_wren_b[port]  = 1'b1;
                exp_wdata_b[port] = data;
            end else begin
                exp_wren_a[port]  = 1'b1;
                exp_wdata_a[port] = data;
            end
        end
    endtask

    // ------------------------------
    // Compare tasks
    // ------------------------------

    task automatic check_word(input string name, input dp_pkg::word_t got,
                              input dp_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_op(input string name, input dp_pkg::alu_op_e got,
                            input dp_pkg::alu_op_e exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("mismatch at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_io(input string name,
                            input logic [dp_pkg::io_port_count-1:0] got_wren,
                            input logic [dp_pkg::io_port_count-1:0] exp_wren,
                            input dp_pkg::io_words_t got_data, input dp_pkg::io_words_t exp_data);
        checks++;
        if (got_wren !== exp_wren) begin
            mismatches++;
            $display("mismatch at %0t: %s io_wren got %b expected %b",
                     $time, name, got_wren, exp_wren);
        end
        for (int i = 0; i < dp_pkg::io_port_count; i++) begin
            if (exp_wren[i] && got_data[i] !== exp_data[i]) begin
                mismatches++;
                $display("mismatch at %0t: %s io_write_data[%0d] got %h expected %h",
                         $time, name, i, got_data[i], exp_data[i]);
            end
        end
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------

    // Low addresses are a hot spot so dependent instructions occur often
    function automatic dp_pkg::addr_t random_addr();
        case ($urandom_range(0, 9))
            0:       return '0;
            1:       return dp_pkg::addr_t'($urandom_range(120, 260));
            2:       return dp_pkg::addr_t'(dp_pkg::io_base_addr + $urandom_range(0, 1));
            3:       return dp_pkg::addr_t'($urandom);
            default: return dp_pkg::addr_t'($urandom_range(1, 12));
        endcase
    endfunction

    function automatic dp_pkg::instr_t random_instr();
        dp_pkg::instr_t in;
        in.issue        = ($urandom_range(0, 7) != 0);
        in.ior          = ($urandom_range(0, 9) == 0);
        in.cancel       = ($urandom_range(0, 9) == 0);
        in.op           = dp_pkg::alu_op_e'($urandom_range(0, 5));
        in.read_addr_a  = random_addr();
        in.read_addr_b  = random_addr();
        in.write_addr_a = random_addr();
        in.write_addr_b = random_addr();
        return in;
    endfunction

    // One clock: model the edge, check outputs, then drive the next inputs
    task automatic step(input dp_pkg::instr_t next);
        dp_pkg::word_t rd_a;
        dp_pkg::word_t rd_b;
        dp_pkg::word_t res;
        @(posedge clock);
        exp_wren_a = '0;
        exp_wren_b = '0;
        rd_a = model_read(1'b0, instr, io_read_data_a);
        rd_b = model_read(1'b1, instr, io_read_data_b);
        res  = model_alu(p1.op, p1_a, p1_b);
        if (!rst_n) begin
            p1 = '0;
            p2 = '0;
        end else begin
            if (p2.issue && !p2.ior && !p2.cancel) begin
                apply_write(1'b0, p2.write_addr_a, p2_res);
                apply_write(1'b1, p2.write_addr_b, p2_res);
            end
            p2     = p1;
            p2_res = res;
            p1     = instr;
        end
        p1_a = rd_a;
        p1_b = rd_b;
        #1;
        check_word("result_valid", dp_pkg::word_t'(result_valid), dp_pkg::word_t'(p2.issue));
        if (p2.issue) begin
            check_word("result", result, p2_res);
            check_op("result_op", result_op, p2.op);
        end
        check_io("bank_a", io_wren_a, exp_wren_a, io_write_data_a, exp_wdata_a);
        check_io("bank_b", io_wren_b, exp_wren_b, io_write_data_b, exp_wdata_b);
        instr          = next;
        io_read_data_a = dp_pkg::io_words_t'($urandom);
        io_read_data_b = dp_pkg::io_words_t'($urandom);
    endtask

    initial begin
        dp_pkg::instr_t first;
        int waited;
        void'($urandom(21));
        checks         = 0;
        mismatches     = 0;
        timeouts       = 0;
        rst_n          = 1'b0;
        instr          = '0;
        io_read_data_a = '0;
        io_read_data_b = '0;
        p1             = '0;
        p2             = '0;
        p1_a           = '0;
        p1_b           = '0;
        p2_res         = '0;
        exp_wren_a     = '0;
        exp_wren_b     = '0;
        exp_wdata_a    = '0;
        exp_wdata_b    = '0;
        for (int i = 0; i < ram_words; i++) begin
            ram_a[i] = '0;
            ram_b[i] = '0;
        end

        repeat (4) step('0);
        rst_n = 1'b1;

        // First issued instruction, then wait for it to come out
        first        = random_instr();
        first.issue  = 1'b1;
        first.ior    = 1'b0;
        first.cancel = 1'b0;
        step(first);
        waited = 0;
        do begin
            step('0);
            waited++;
        end while (!result_valid && waited < wait_limit);
        if (!result_valid) begin
            timeouts++;
            $display("timeout: no result_valid within %0d cycles of the first issue", wait_limit);
        end

        repeat (run_cycles) step(random_instr());
        repeat (4) step('0);

        $display("Summary: %0d checks, %0d mismatches, %0d timeouts, %0d assertion failures",
                 checks, mismatches, timeouts, DUT.assertions.failures);
        if (mismatches == 0 && timeouts == 0 && DUT.assertions.failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
verilog/dp_pkg.sv
verilog/mem_addressing.sv
verilog/data_memory.sv
verilog/datapath_alu.sv
verilog/datapath_top.sv
bench/datapath_assert.sv
bench/tb_datapath.sv

// ==== Bender.yml ====
package:
  name: datapath

sources:
  # Design, in compile order
  - verilog/dp_pkg.sv
  - verilog/mem_addressing.sv
  - verilog/data_memory.sv
  - verilog/datapath_alu.sv
  - verilog/datapath_top.sv

  # Testbench and bound assertions
  - target: test
    files:
      - bench/datapath_assert.sv
      - bench/tb_datapath.sv
